// ==== src/mipsPkg.sv ====
//==========================================================================
// shared encodings for the single-cycle MIPS subset core
// only add, sub, and, or, slt, lw, sw, beq, j, jal and jr are decoded
// every other opcode or funct value is treated as a no-op by the core
//==========================================================================
`default_nettype none

package mipsPkg;

  //========================================================================
  // primary opcode values, bits 31:26
  //========================================================================
  localparam logic [5:0] opSpecial = 6'h00;
  localparam logic [5:0] opJ       = 6'h02;
  localparam logic [5:0] opJal     = 6'h03;
  localparam logic [5:0] opBeq     = 6'h04;
  localparam logic [5:0] opLw      = 6'h23;
  localparam logic [5:0] opSw      = 6'h2b;

  // funct values under opSpecial
  localparam logic [5:0] fnJr  = 6'h08;
  localparam logic [5:0] fnAdd = 6'h20;
  localparam logic [5:0] fnSub = 6'h22;
  localparam logic [5:0] fnAnd = 6'h24;
  localparam logic [5:0] fnOr  = 6'h25;
  localparam logic [5:0] fnSlt = 6'h2a;

  // jal link destination
  localparam logic [4:0] linkReg = 5'd31;

  // coarse ALU request from decode
  typedef enum logic [1:0] {
    aluAdd,
    aluSub,
    aluFunct
  } aluOpKind;

  // resolved ALU operation
  typedef enum logic [2:0] {
    ctlAnd,
    ctlOr,
    ctlAdd,
    ctlSub,
    ctlSlt,
    ctlNone
  } aluCtrl;

  //========================================================================
  // instruction word views
  //========================================================================
  typedef struct packed {
    logic [5:0] opcode;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt;
    logic [5:0] funct;
  } rFields;

  typedef struct packed {
    logic [5:0]  opcode;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] imm;
  } iFields;

  typedef struct packed {
    logic [5:0]  opcode;
    logic [25:0] target;
  } jFields;

  // one 32-bit word, three decodings
  typedef union packed {
    rFields rType;
    iFields iType;
    jFields jType;
  } instrWord;

endpackage

`default_nettype wire

// ==== src/fetchStage.sv ====
//==========================================================================
// program counter and next-PC selection
// priority is jump, then taken beq, then jr, then sequential
// no delay slot, PC is byte addressed and always word aligned
//==========================================================================
`timescale 1ns/1ns
`default_nettype none

module fetchStage #(
  parameter logic [31:0] resetPc = 32'h0000_0000
) (
  input  wire logic        clk,
  input  wire logic        rst,
  input  wire logic        jump,
  input  wire logic        jumpReg,
  input  wire logic        branch,
  input  wire logic        zero,
  input  wire logic [31:0] branchTarget,
  input  wire logic [25:0] jumpTarget,
  input  wire logic [31:0] rsData,
  output logic      [31:0] pc,
  output logic      [31:0] pcPlus4
);

  logic [31:0] jumpAddr;
  logic        takeBranch;
  logic [31:0] nextPc;

  // sequential address, also the jal link value
  assign pcPlus4 = pc + 32'd4;

  // j and jal stay inside the current 256 MB region
  assign jumpAddr = {pcPlus4[31:28], jumpTarget, 2'b00};

  // beq taken when the subtract came out zero
  assign takeBranch = branch & zero;

  //========================================================================
  // next PC
  //========================================================================
  always_comb begin
    if (jump) begin
      nextPc = jumpAddr;
    end else if (takeBranch) begin
      nextPc = branchTarget;
    end else if (jumpReg) begin
      // jr target straight from rs
      nextPc = rsData;
    end else begin
      nextPc = pcPlus4;
    end
  end

  // pc register
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pc <= resetPc;
    end else begin
      pc <= nextPc;
    end
  end

endmodule

`default_nettype wire

// ==== src/decodeStage.sv ====
//==========================================================================
// instruction decode, purely combinational
// unknown opcodes and unknown R-type functs raise no write or memory level
// immediate is always sign extended, no zero-extended forms exist here
//==========================================================================
`timescale 1ns/1ns
`default_nettype none

module decodeStage (
  input  wire mipsPkg::instrWord instr,
  output logic              [4:0]  rsAddr,
  output logic              [4:0]  rtAddr,
  output logic              [4:0]  rdAddr,
  output logic              [5:0]  funct,
  output logic              [31:0] immExt,
  output logic              [25:0] jumpTarget,
  output logic                     regWrite,
  output logic                     regDst,
  output logic                     link,
  output logic                     memRead,
  output logic                     memWrite,
  output logic                     memToReg,
  output logic                     aluSrc,
  output mipsPkg::aluOpKind        aluOp,
  output logic                     branch,
  output logic                     jump,
  output logic                     jumpReg
);

  logic [5:0] opcode;
  logic       isAluFunct;

  // opcode sits in the same place in every view
  assign opcode    = instr.jType.opcode;

  //========================================================================
  // field selects
  //========================================================================
  // rs and rt shared by R and I forms
  assign rsAddr     = instr.rType.rs;
  assign rtAddr     = instr.iType.rt;
  assign rdAddr     = instr.rType.rd;
  assign funct      = instr.rType.funct;
  assign jumpTarget = instr.jType.target;

  // sign extension of the 16-bit immediate
  assign immExt = {{16{instr.iType.imm[15]}}, instr.iType.imm};

  // R-type functs that go through the ALU and write rd
  always_comb begin
    case (instr.rType.funct)
      mipsPkg::fnAdd, mipsPkg::fnSub, mipsPkg::fnAnd,
      mipsPkg::fnOr, mipsPkg::fnSlt: isAluFunct = 1'b1;
      default:                       isAluFunct = 1'b0;
    endcase
  end

  //========================================================================
  // control levels
  //========================================================================
  always_comb begin
    // defaults give a no-op
    regWrite = 1'b0;
    regDst   = 1'b0;
    link     = 1'b0;
    memRead  = 1'b0;
    memWrite = 1'b0;
    memToReg = 1'b0;
    aluSrc   = 1'b0;
    aluOp    = mipsPkg::aluAdd;
    branch   = 1'b0;
    jump     = 1'b0;
    jumpReg  = 1'b0;
    case (opcode)
      mipsPkg::opSpecial: begin
        regDst   = 1'b1;
        aluOp    = mipsPkg::aluFunct;
        regWrite = isAluFunct;
        jumpReg  = (instr.rType.funct == mipsPkg::fnJr);
      end
      mipsPkg::opLw: begin
        regWrite = 1'b1;
        memRead  = 1'b1;
        memToReg = 1'b1;
        aluSrc   = 1'b1;
      end
      mipsPkg::opSw: begin
        memWrite = 1'b1;
        aluSrc   = 1'b1;
      end
      // compare by subtraction
      mipsPkg::opBeq: begin
        branch = 1'b1;
        aluOp  = mipsPkg::aluSub;
      end
      mipsPkg::opJ: begin
        jump = 1'b1;
      end
      mipsPkg::opJal: begin
        jump     = 1'b1;
        link     = 1'b1;
        regWrite = 1'b1;
      end
      default: begin
        regWrite = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== src/regFile.sv ====
//==========================================================================
// 31 general registers, register 0 is hardwired to zero
// two combinational reads, one write at the rising edge
// a write is seen by reads only in the following cycle, no bypass
//==========================================================================
`timescale 1ns/1ns
`default_nettype none

module regFile (
  input  wire logic        clk,
  input  wire logic        rst,
  input  wire logic [4:0]  rsAddr,
  input  wire logic [4:0]  rtAddr,
  input  wire logic        wrEn,
  input  wire logic [4:0]  wrAddr,
  input  wire logic [31:0] wrData,
  output logic      [31:0] rsData,
  output logic      [31:0] rtData
);

  // no storage behind address 0
  logic [31:0] regs [1:31];

  //========================================================================
  // write port
  //========================================================================
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wrEn && (wrAddr != 5'd0)) begin
      regs[wrAddr] <= wrData;
    end
  end

  //========================================================================
  // read ports
  //========================================================================
  // address 0 reads as zero
  assign rsData = (rsAddr == 5'd0) ? 32'd0 : regs[rsAddr];
  assign rtData = (rtAddr == 5'd0) ? 32'd0 : regs[rtAddr];

endmodule

`default_nettype wire

// ==== src/executeStage.sv ====
//==========================================================================
// ALU control, operand select, ALU and branch target
// slt compares signed, unknown functs give a zero result
// zero flag follows every result, decode decides whether it matters
//==========================================================================
`timescale 1ns/1ns
`default_nettype none

module executeStage (
  input  wire logic              [31:0] rsData,
  input  wire logic              [31:0] rtData,
  input  wire logic              [31:0] immExt,
  input  wire logic                     aluSrc,
  input  wire mipsPkg::aluOpKind        aluOp,
  input  wire logic              [5:0]  funct,
  input  wire logic              [31:0] pcPlus4,
  output logic                   [31:0] aluResult,
  output logic                          zero,
  output logic                   [31:0] branchTarget
);

  mipsPkg::aluCtrl ctl;
  logic [31:0]     opB;

  //========================================================================
  // ALU control
  //========================================================================
  always_comb begin
    case (aluOp)
      // lw and sw address
      mipsPkg::aluAdd: ctl = mipsPkg::ctlAdd;
      // beq compare
      mipsPkg::aluSub: ctl = mipsPkg::ctlSub;
      default: begin
        case (funct)
          mipsPkg::fnAdd: ctl = mipsPkg::ctlAdd;
          mipsPkg::fnSub: ctl = mipsPkg::ctlSub;
          mipsPkg::fnAnd: ctl = mipsPkg::ctlAnd;
          mipsPkg::fnOr:  ctl = mipsPkg::ctlOr;
          mipsPkg::fnSlt: ctl = mipsPkg::ctlSlt;
          default:        ctl = mipsPkg::ctlNone;
        endcase
      end
    endcase
  end

  // second operand, immediate for memory ops
  assign opB = aluSrc ? immExt : rtData;

  //========================================================================
  // ALU
  //========================================================================
  always_comb begin
    case (ctl)
      mipsPkg::ctlAdd: aluResult = rsData + opB;
      mipsPkg::ctlSub: aluResult = rsData - opB;
      mipsPkg::ctlAnd: aluResult = rsData & opB;
      mipsPkg::ctlOr:  aluResult = rsData | opB;
      mipsPkg::ctlSlt: aluResult = {31'd0, $signed(rsData) < $signed(opB)};
      default:         aluResult = 32'd0;
    endcase
  end

  assign zero = (aluResult == 32'd0);

  // word offset relative to the next instruction
  assign branchTarget = pcPlus4 + {immExt[29:0], 2'b00};

endmodule

`default_nettype wire

// ==== src/memWriteback.sv ====
//==========================================================================
// data memory strobes and writeback select
// strobes are active low and held inactive while rst is low
// memory must return readData in the same cycle as dataAddr
//==========================================================================
`timescale 1ns/1ns
`default_nettype none

module memWriteback #(
  parameter int dataAddrWidth = 7
) (
  input  wire logic                     rst,
  input  wire logic                     memRead,
  input  wire logic                     memWrite,
  input  wire logic                     memToReg,
  input  wire logic                     regDst,
  input  wire logic                     link,
  input  wire logic                     regWrite,
  input  wire logic [4:0]               rtAddr,
  input  wire logic [4:0]               rdAddr,
  input  wire logic [31:0]              aluResult,
  input  wire logic [31:0]              rtData,
  input  wire logic [31:0]              readData,
  input  wire logic [31:0]              pcPlus4,
  output logic                          cen,
  output logic                          wen,
  output logic      [dataAddrWidth-1:0] dataAddr,
  output logic      [31:0]              writeData,
  output logic                          wrEn,
  output logic      [4:0]               wrAddr,
  output logic      [31:0]              wrData
);

  //========================================================================
  // memory port
  //========================================================================
  // chip enable for lw and sw, write enable for sw only
  assign cen       = ~(rst & (memRead | memWrite));
  assign wen       = ~(rst & memWrite);
  // word address, byte offset dropped
  assign dataAddr  = aluResult[dataAddrWidth+1:2];
  assign writeData = rtData;

  //========================================================================
  // writeback
  //========================================================================
  assign wrEn = regWrite;

  // jal to r31, R-type to rd, lw to rt
  assign wrAddr = link ? mipsPkg::linkReg : (regDst ? rdAddr : rtAddr);

  // link value, load data or ALU result
  assign wrData = link ? pcPlus4 : (memToReg ? readData : aluResult);

endmodule

`default_nettype wire

// ==== src/singleCycleCore.sv ====
//==========================================================================
// single-cycle MIPS subset core, all stages settle in one clock
// instruction and data memories are external and answer combinationally
// rfWriteData mirrors the register file write data for test
//==========================================================================
`timescale 1ns/1ns
`default_nettype none

module singleCycleCore #(
  parameter logic [31:0] resetPc       = 32'h0000_0000,
  parameter int          dataAddrWidth = 7
) (
  input  wire logic                     clk,
  input  wire logic                     rst,
  output logic      [31:0]              instrAddr,
  input  wire logic [31:0]              instr,
  output logic                          cen,
  output logic                          wen,
  output logic      [dataAddrWidth-1:0] dataAddr,
  output logic      [31:0]              writeData,
  input  wire logic [31:0]              readData,
  output logic      [31:0]              rfWriteData
);

  //========================================================================
  // stage interconnect
  //========================================================================
  // fetch
  logic [31:0] pcPlus4;
  // decode
  logic [4:0]        rsAddr;
  logic [4:0]        rtAddr;
  logic [4:0]        rdAddr;
  logic [5:0]        funct;
  logic [31:0]       immExt;
  logic [25:0]       jumpTarget;
  logic              regWrite;
  logic              regDst;
  logic              link;
  logic              memRead;
  logic              memWrite;
  logic              memToReg;
  logic              aluSrc;
  mipsPkg::aluOpKind aluOp;
  logic              branch;
  logic              jump;
  logic              jumpReg;
  // register file
  logic [31:0] rsData;
  logic [31:0] rtData;
  // execute
  logic [31:0] aluResult;
  logic        zero;
  logic [31:0] branchTarget;
  // writeback
  logic        wrEn;
  logic [4:0]  wrAddr;

  fetchStage #(
    .resetPc(resetPc)
  ) uFetch (
    .clk         (clk),
    .rst         (rst),
    .jump        (jump),
    .jumpReg     (jumpReg),
    .branch      (branch),
    .zero        (zero),
    .branchTarget(branchTarget),
    .jumpTarget  (jumpTarget),
    .rsData      (rsData),
    .pc          (instrAddr),
    .pcPlus4     (pcPlus4)
  );

  decodeStage uDecode (
    .instr     (instr),
    .rsAddr    (rsAddr),
    .rtAddr    (rtAddr),
    .rdAddr    (rdAddr),
    .funct     (funct),
    .immExt    (immExt),
    .jumpTarget(jumpTarget),
    .regWrite  (regWrite),
    .regDst    (regDst),
    .link      (link),
    .memRead   (memRead),
    .memWrite  (memWrite),
    .memToReg  (memToReg),
    .aluSrc    (aluSrc),
    .aluOp     (aluOp),
    .branch    (branch),
    .jump      (jump),
    .jumpReg   (jumpReg)
  );

  // write data taken from the exported test port
  regFile uRegs (
    .clk   (clk),
    .rst   (rst),
    .rsAddr(rsAddr),
    .rtAddr(rtAddr),
    .wrEn  (wrEn),
    .wrAddr(wrAddr),
    .wrData(rfWriteData),
    .rsData(rsData),
    .rtData(rtData)
  );

  executeStage uExecute (
    .rsData      (rsData),
    .rtData      (rtData),
    .immExt      (immExt),
    .aluSrc      (aluSrc),
    .aluOp       (aluOp),
    .funct       (funct),
    .pcPlus4     (pcPlus4),
    .aluResult   (aluResult),
    .zero        (zero),
    .branchTarget(branchTarget)
  );

  memWriteback #(
    .dataAddrWidth(dataAddrWidth)
  ) uMemWb (
    .rst      (rst),
    .memRead  (memRead),
    .memWrite (memWrite),
    .memToReg (memToReg),
    .regDst   (regDst),
    .link     (link),
    .regWrite (regWrite),
    .rtAddr   (rtAddr),
    .rdAddr   (rdAddr),
    .aluResult(aluResult),
    .rtData   (rtData),
    .readData (readData),
    .pcPlus4  (pcPlus4),
    .cen      (cen),
    .wen      (wen),
    .dataAddr (dataAddr),
    .writeData(writeData),
    .wrEn     (wrEn),
    .wrAddr   (wrAddr),
    .wrData   (rfWriteData)
  );

endmodule

`default_nettype wire

// ==== bench/core_chk.sv ====
//==========================================================================
// port-level assertions, bound into every singleCycleCore
// failCount is read by the testbench to end the run
//==========================================================================
`timescale 1ns/1ns
`default_nettype none

module coreChk #(
  parameter logic [31:0] resetPc = 32'h0000_0000
) (
  input  wire logic        clk,
  input  wire logic        rst,
  input  wire logic [31:0] instrAddr,
  input  wire logic        cen,
  input  wire logic        wen
);

  // failed properties so far
  int failCount = 0;

  // strobes stay inactive through reset
  resetIdle: assert property (@(posedge clk) !rst |-> (cen && wen))
    else begin
      $error("data strobes active while rst is low");
      failCount = failCount + 1;
    end

  // pc parked at its reset value
  resetPcHeld: assert property (@(posedge clk) !rst |-> (instrAddr == resetPc))
    else begin
      $error("instrAddr left resetPc during reset");
      failCount = failCount + 1;
    end

  // first fetch after release
  firstFetch: assert property (@(posedge clk) $rose(rst) |-> (instrAddr == resetPc))
    else begin
      $error("first fetch after reset is not resetPc");
      failCount = failCount + 1;
    end

  // a write always comes with chip enable
  writeNeedsChip: assert property (@(posedge clk) !wen |-> !cen)
    else begin
      $error("wen low without cen");
      failCount = failCount + 1;
    end

  // word aligned fetch
  alignedFetch: assert property (@(posedge clk) rst |-> (instrAddr[1:0] == 2'b00))
    else begin
      $error("instrAddr not word aligned");
      failCount = failCount + 1;
    end

endmodule

bind singleCycleCore coreChk #(
  .resetPc(resetPc)
) chk (
  .clk      (clk),
  .rst      (rst),
  .instrAddr(instrAddr),
  .cen      (cen),
  .wen      (wen)
);

`default_nettype wire

// ==== bench/coreTb.sv ====
//==========================================================================
// testbench for the single-cycle core with a random program
// control flow is forward only and ends in a self-loop, resetPc is 0
// jr always uses r30, loaded once with a fixed forward address
//==========================================================================
`timescale 1ns/1ns
`default_nettype none

module coreTb;

  localparam logic [31:0] resetPc  = 32'h0000_0000;
  localparam int          loopIdx  = 91;
  localparam int          jrIdx    = 70;
  localparam int          jrTarget = 80;
  localparam int          progLen  = loopIdx + 1;

  logic        clk;
  logic        rst;
  logic [31:0] instrAddr;
  logic [31:0] instr;
  logic        cen;
  logic        wen;
  logic [6:0]  dataAddr;
  logic [31:0] writeData;
  logic [31:0] readData;
  logic [31:0] rfWriteData;

  logic [31:0] rom [0:127];
  logic [31:0] ram [0:127];
  // architectural state as the rules predict it
  logic [31:0] shadowRegs [0:31];
  logic [31:0] shadowPc;
  integer      seed;

  singleCycleCore #(
    .resetPc      (resetPc),
    .dataAddrWidth(7)
  ) dut (
    .clk        (clk),
    .rst        (rst),
    .instrAddr  (instrAddr),
    .instr      (instr),
    .cen        (cen),
    .wen        (wen),
    .dataAddr   (dataAddr),
    .writeData  (writeData),
    .readData   (readData),
    .rfWriteData(rfWriteData)
  );

  // both memories answer in the same cycle
  assign instr    = rom[instrAddr[8:2]];
  assign readData = ram[dataAddr];

  always @(posedge clk) begin
    if (!cen && !wen) begin
      ram[dataAddr] = writeData;
    end
  end

  initial clk = 1'b0;
  always #2 clk = ~clk;

  //========================================================================
  // error exits
  //========================================================================
  task automatic abortRun(input string line);
    $display("%s", line);
    $display("Something failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic mismatch(input string what);
    abortRun($sformatf("MISMATCH at %0t ns: %s", $time, what));
  endtask

  function automatic int pick(input int n);
    return ($random(seed) & 32'h7fff_ffff) % n;
  endfunction

  function automatic logic isKept(input logic [5:0] op);
    return op inside {mipsPkg::opSpecial, mipsPkg::opLw, mipsPkg::opSw,
                      mipsPkg::opBeq, mipsPkg::opJ, mipsPkg::opJal};
  endfunction

  function automatic mipsPkg::aluCtrl ctlFor(input logic [5:0] fn);
    case (fn)
      mipsPkg::fnAdd: return mipsPkg::ctlAdd;
      mipsPkg::fnSub: return mipsPkg::ctlSub;
      mipsPkg::fnAnd: return mipsPkg::ctlAnd;
      mipsPkg::fnOr:  return mipsPkg::ctlOr;
      mipsPkg::fnSlt: return mipsPkg::ctlSlt;
      default:        return mipsPkg::ctlNone;
    endcase
  endfunction

  // expected R-type result
  function automatic logic [31:0] aluRule(input mipsPkg::aluCtrl c,
                                          input logic [31:0] a,
                                          input logic [31:0] b);
    case (c)
      mipsPkg::ctlAdd: return a + b;
      mipsPkg::ctlSub: return a - b;
      mipsPkg::ctlAnd: return a & b;
      mipsPkg::ctlOr:  return a | b;
      mipsPkg::ctlSlt: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      default:         return 32'd0;
    endcase
  endfunction

  //========================================================================
  // program and data image
  //========================================================================
  task automatic buildProgram;
    mipsPkg::instrWord w;
    int                kind;
    int                target;
    logic [5:0]        op;
    for (int i = 0; i < 128; i++) begin
      // spare words jump to themselves
      rom[i] = {mipsPkg::opJ, 26'(i)};
      ram[i] = $random(seed);
    end
    ram[30] = 32'(jrTarget * 4);
    // prologue, lw r1..r31 from ram[1..31]
    for (int r = 1; r < 32; r++) begin
      w = '0;
      w.iType.opcode = mipsPkg::opLw;
      w.iType.rt = 5'(r);
      w.iType.imm = 16'(r * 4);
      rom[r - 1] = w;
    end
    for (int i = 31; i < loopIdx; i++) begin
      w = '0;
      kind = pick(10);
      target = i + 1 + pick(4);
      if (target > loopIdx) begin
        target = loopIdx;
      end
      // never skip the jr word
      if (i < jrIdx && target > jrIdx) begin
        target = jrIdx;
      end
      if (i == jrIdx) begin
        w.rType.rs = 5'd30;
        w.rType.funct = mipsPkg::fnJr;
      end else if (kind < 5) begin
        w.rType.rs = 5'(pick(32));
        w.rType.rt = 5'(pick(32));
        // r30 stays reserved, rd 0 allowed
        w.rType.rd = 5'(pick(30));
        case (pick(5))
          0:       w.rType.funct = mipsPkg::fnAdd;
          1:       w.rType.funct = mipsPkg::fnSub;
          2:       w.rType.funct = mipsPkg::fnAnd;
          3:       w.rType.funct = mipsPkg::fnOr;
          default: w.rType.funct = mipsPkg::fnSlt;
        endcase
      end else if (kind < 7) begin
        w.iType.opcode = (kind == 5) ? mipsPkg::opLw : mipsPkg::opSw;
        w.iType.rs = 5'(pick(32));
        w.iType.rt = (kind == 5) ? 5'(1 + pick(29)) : 5'(pick(32));
        w.iType.imm = 16'(pick(65536));
      end else if (kind == 7) begin
        w.iType.opcode = mipsPkg::opBeq;
        w.iType.rs = 5'(pick(32));
        // equal operands half the time
        w.iType.rt = (pick(2) == 0) ? w.iType.rs : 5'(pick(32));
        w.iType.imm = 16'(target - i - 1);
      end else if (kind == 8) begin
        w.jType.opcode = (pick(2) == 0) ? mipsPkg::opJ : mipsPkg::opJal;
        w.jType.target = 26'(target);
      end else begin
        // unknown opcode, random fields
        w = $random(seed);
        op = 6'(pick(64));
        if (isKept(op)) begin
          op = 6'h3f;
        end
        w.jType.opcode = op;
      end
      rom[i] = w;
    end
  endtask

  //========================================================================
  // one retired instruction against the shadow model
  //========================================================================
  task automatic checkStep;
    mipsPkg::instrWord w;
    logic [31:0]       a;
    logic [31:0]       b;
    logic [31:0]       immExt;
    logic [31:0]       addr;
    logic [31:0]       expected;
    logic [31:0]       nextPc;
    w = rom[shadowPc[8:2]];
    a = shadowRegs[w.rType.rs];
    b = shadowRegs[w.rType.rt];
    immExt = {{16{w.iType.imm[15]}}, w.iType.imm};
    addr = a + immExt;
    nextPc = shadowPc + 32'd4;
    assert (instrAddr == shadowPc)
      else mismatch($sformatf("instrAddr %h, expected %h", instrAddr, shadowPc));
    if (w.iType.opcode == mipsPkg::opLw) begin
      assert (!cen && wen) else mismatch("lw strobes wrong");
      assert (dataAddr == addr[8:2])
        else mismatch($sformatf("lw dataAddr %h, expected %h", dataAddr, addr[8:2]));
      expected = ram[addr[8:2]];
      assert (rfWriteData == expected)
        else mismatch($sformatf("lw data %h, expected %h", rfWriteData, expected));
      if (w.iType.rt != 5'd0) begin
        shadowRegs[w.iType.rt] = expected;
      end
    end else if (w.iType.opcode == mipsPkg::opSw) begin
      assert (!cen && !wen) else mismatch("sw strobes wrong");
      assert (dataAddr == addr[8:2])
        else mismatch($sformatf("sw dataAddr %h, expected %h", dataAddr, addr[8:2]));
      assert (writeData == b)
        else mismatch($sformatf("sw writeData %h, expected %h", writeData, b));
    end else begin
      // everything else leaves the data port idle
      assert (cen && wen) else mismatch("data strobes active for a non-memory word");
      case (w.iType.opcode)
        mipsPkg::opSpecial: begin
          if (w.rType.funct == mipsPkg::fnJr) begin
            nextPc = a;
          end else if (ctlFor(w.rType.funct) != mipsPkg::ctlNone) begin
            expected = aluRule(ctlFor(w.rType.funct), a, b);
            assert (rfWriteData == expected)
              else mismatch($sformatf("R-type result %h, expected %h",
                                      rfWriteData, expected));
            if (w.rType.rd != 5'd0) begin
              shadowRegs[w.rType.rd] = expected;
            end
          end
        end
        mipsPkg::opBeq: begin
          if (a == b) begin
            nextPc = shadowPc + 32'd4 + (immExt << 2);
          end
        end
        mipsPkg::opJ: begin
          nextPc = {nextPc[31:28], w.jType.target, 2'b00};
        end
        mipsPkg::opJal: begin
          assert (rfWriteData == shadowPc + 32'd4)
            else mismatch($sformatf("jal link %h, expected %h",
                                    rfWriteData, shadowPc + 32'd4));
          shadowRegs[mipsPkg::linkReg] = shadowPc + 32'd4;
          nextPc = {nextPc[31:28], w.jType.target, 2'b00};
        end
        default: begin
          // unknown word, pc + 4 only
        end
      endcase
    end
    shadowPc = nextPc;
  endtask

  //========================================================================
  // main sequence
  //========================================================================
  initial begin
    int steps;
    int loopHits;
    seed = 34954;
    rst = 1'b0;
    shadowPc = resetPc;
    for (int r = 0; r < 32; r++) begin
      shadowRegs[r] = '0;
    end
    buildProgram();
    // reset phase, 8 rising edges
    repeat (8) begin
      @(posedge clk);
      #1;
      assert (cen && wen) else mismatch("data strobes active during reset");
      assert (instrAddr == resetPc)
        else mismatch($sformatf("instrAddr %h during reset", instrAddr));
    end
    rst = 1'b1;
    steps = 0;
    loopHits = 0;
    // check mid-cycle, once settled
    while (loopHits < 2 && steps < 2 * progLen) begin
      @(negedge clk);
      if (shadowPc == 32'(loopIdx * 4)) begin
        loopHits = loopHits + 1;
      end
      checkStep();
      steps = steps + 1;
    end
    if (dut.chk.failCount != 0) begin
      abortRun("a port assertion in the bound checker failed");
    end else if (loopHits == 2) begin
      $display("Everything OK");
      $finish;
    end else begin
      abortRun("the program did not reach its final loop");
    end
  end

  // bound checker flags
  always @(negedge clk) begin
    if (dut.chk.failCount != 0) begin
      abortRun("a port assertion in the bound checker failed");
    end
  end

  // watchdog
  initial begin
    #((8 + progLen * 3) * 4);
    abortRun("timeout, the run took longer than the program allows");
  end

endmodule

`default_nettype wire

// ==== flist.f ====
src/mipsPkg.sv
src/fetchStage.sv
src/decodeStage.sv
src/regFile.sv
src/executeStage.sv
src/memWriteback.sv
src/singleCycleCore.sv
bench/core_chk.sv
bench/coreTb.sv

// ==== Makefile ====
# Verilator build and run of the single-cycle core testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f flist.f --top-module coreTb -o coreSim
	-./obj_dir/coreSim +verilator+error+limit+100 > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Everything OK" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
